// ==== irq_pkg.sv ====
`default_nettype none

package irq_pkg;

  // number of external interrupt lines
  localparam int INT_VECT_LEN = 8;

  // width of a line index
  localparam int OFFSET_LEN = $clog2(INT_VECT_LEN);

  // core address and data width
  localparam int XLEN = 32;

  // one bit per interrupt line
  typedef logic [INT_VECT_LEN-1:0] irq_vec_t;

  // binary line number
  typedef logic [OFFSET_LEN-1:0] irq_idx_t;

  // trap and vector base addresses
  typedef logic [XLEN-1:0] xaddr_t;

  // controller handshake with the core
  // encoding is visible to software through the active register
  typedef enum logic [1:0] {
    IRQ_IDLE    = 2'b00,
    IRQ_PENDING = 2'b01,
    IRQ_TAKEN   = 2'b10
  } irq_state_e;

endpackage

`default_nettype wire

// ==== axil_pkg.sv ====
`default_nettype none

package axil_pkg;

  // register port address width
  localparam int AXIL_AW = 4;

  // register port data width
  localparam int AXIL_DW = 32;

  typedef logic [AXIL_AW-1:0] axil_addr_t;
  typedef logic [AXIL_DW-1:0] axil_data_t;
  typedef logic [AXIL_DW/8-1:0] axil_strb_t;
  typedef logic [1:0] axil_resp_t;

  // response codes
  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  // register map
  localparam axil_addr_t REG_MASK    = 4'h0;
  localparam axil_addr_t REG_PENDING = 4'h4;
  localparam axil_addr_t REG_VBASE   = 4'h8;
  localparam axil_addr_t REG_ACTIVE  = 4'hC;

  // master to slave channels
  typedef struct packed {
    axil_addr_t addr;
    logic       valid;
  } axil_aw_t;

  typedef struct packed {
    axil_data_t data;
    axil_strb_t strb;
    logic       valid;
  } axil_w_t;

  typedef struct packed {
    axil_addr_t addr;
    logic       valid;
  } axil_ar_t;

  typedef struct packed {
    axil_aw_t aw;
    axil_w_t  w;
    axil_ar_t ar;
    logic     bready;
    logic     rready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic       awready;
    logic       wready;
    axil_resp_t bresp;
    logic       bvalid;
    logic       arready;
    axil_data_t rdata;
    axil_resp_t rresp;
    logic       rvalid;
  } axil_rsp_t;

endpackage

`default_nettype wire

// ==== irq_edge_sync.sv ====
`default_nettype none

module irq_edge_sync (
  input  wire               clk_i,
  input  wire               reset_i,
  input  wire irq_pkg::irq_vec_t irq_lines_i,
  output irq_pkg::irq_vec_t irq_rise_o
);

  // two stage synchronizer
  irq_pkg::irq_vec_t sync_meta_q;
  irq_pkg::irq_vec_t sync_q;

  // last synchronized value for edge detect
  irq_pkg::irq_vec_t prev_q;

  // registered rise pulses
  irq_pkg::irq_vec_t rise_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_meta_q <= '0;
      sync_q      <= '0;
      prev_q      <= '0;
      rise_q      <= '0;
    end else begin
      sync_meta_q <= irq_lines_i;
      sync_q      <= sync_meta_q;
      prev_q      <= sync_q;
      // one pulse per low to high transition
      rise_q      <= sync_q & ~prev_q;
    end
  end

  assign irq_rise_o = rise_q;

endmodule

`default_nettype wire

// ==== axil_irq_regs.sv ====
`default_nettype none

module axil_irq_regs (
  input  wire                         clk_i,
  input  wire                         reset_i,
  input  wire axil_pkg::axil_req_t    axil_req_i,
  output axil_pkg::axil_rsp_t         axil_rsp_o,
  input  wire irq_pkg::irq_vec_t      pending_i,
  input  wire irq_pkg::irq_vec_t      active_i,
  input  wire irq_pkg::irq_state_e    state_i,
  output irq_pkg::irq_vec_t           irq_mask_o,
  output irq_pkg::xaddr_t             vector_base_o
);

  // configuration registers
  irq_pkg::irq_vec_t mask_q;
  irq_pkg::xaddr_t   vbase_q;

  // write channel
  logic                 wr_ready_q;
  logic                 bvalid_q;
  axil_pkg::axil_resp_t bresp_q;
  logic                 wr_fire;
  logic                 wr_err;

  // read channel
  logic                 arready_q;
  logic                 rvalid_q;
  axil_pkg::axil_data_t rdata_q;
  axil_pkg::axil_resp_t rresp_q;
  logic                 rd_fire;
  logic                 rd_err;
  axil_pkg::axil_data_t rd_data;

  // merge new data into old value under the byte strobes
  function automatic axil_pkg::axil_data_t apply_strb(
    input axil_pkg::axil_data_t old_val,
    input axil_pkg::axil_data_t new_val,
    input axil_pkg::axil_strb_t strb
  );
    axil_pkg::axil_data_t result;
    result = old_val;
    for (int b = 0; b < axil_pkg::AXIL_DW / 8; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return result;
  endfunction

  // aw and w are taken together in one cycle
  assign wr_fire = wr_ready_q && axil_req_i.aw.valid && axil_req_i.w.valid;
  assign rd_fire = arready_q && axil_req_i.ar.valid;

  always_comb begin
    case (axil_req_i.aw.addr)
      axil_pkg::REG_MASK,
      axil_pkg::REG_PENDING,
      axil_pkg::REG_VBASE,
      axil_pkg::REG_ACTIVE: wr_err = 1'b0;
      default:              wr_err = 1'b1;
    endcase
  end

  // status is sampled in the handshake cycle
  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    case (axil_req_i.ar.addr)
      axil_pkg::REG_MASK:    rd_data = axil_pkg::axil_data_t'(mask_q);
      axil_pkg::REG_PENDING: rd_data = axil_pkg::axil_data_t'(pending_i);
      axil_pkg::REG_VBASE:   rd_data = axil_pkg::axil_data_t'(vbase_q);
      // state in the bits above the one-hot active line
      axil_pkg::REG_ACTIVE:  rd_data = axil_pkg::axil_data_t'({state_i, active_i});
      default:               rd_err  = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ready_q <= 1'b0;
      bvalid_q   <= 1'b0;
      mask_q     <= '0;
      vbase_q    <= '0;
    end else begin
      // single cycle ready, blocked while a response is held
      wr_ready_q <= axil_req_i.aw.valid && axil_req_i.w.valid &&
                    !bvalid_q && !wr_ready_q;
      if (wr_fire) begin
        bvalid_q <= 1'b1;
        case (axil_req_i.aw.addr)
          axil_pkg::REG_MASK: begin
            mask_q <= irq_pkg::irq_vec_t'(apply_strb(axil_pkg::axil_data_t'(mask_q),
                                                     axil_req_i.w.data,
                                                     axil_req_i.w.strb));
          end
          axil_pkg::REG_VBASE: begin
            // word aligned base
            vbase_q <= irq_pkg::xaddr_t'(apply_strb(axil_pkg::axil_data_t'(vbase_q),
                                                    axil_req_i.w.data,
                                                    axil_req_i.w.strb)) & ~32'h3;
          end
          default: ;
        endcase
      end else if (bvalid_q && axil_req_i.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      bresp_q <= wr_err ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else begin
      arready_q <= axil_req_i.ar.valid && !rvalid_q && !arready_q;
      if (rd_fire) begin
        rvalid_q <= 1'b1;
      end else if (rvalid_q && axil_req_i.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      rdata_q <= rd_data;
      rresp_q <= rd_err ? axil_pkg::RESP_SLVERR : axil_pkg::RESP_OKAY;
    end
  end

  assign axil_rsp_o.awready = wr_ready_q;
  assign axil_rsp_o.wready  = wr_ready_q;
  assign axil_rsp_o.bresp   = bresp_q;
  assign axil_rsp_o.bvalid  = bvalid_q;
  assign axil_rsp_o.arready = arready_q;
  assign axil_rsp_o.rdata   = rdata_q;
  assign axil_rsp_o.rresp   = rresp_q;
  assign axil_rsp_o.rvalid  = rvalid_q;

  assign irq_mask_o    = mask_q;
  assign vector_base_o = vbase_q;

endmodule

`default_nettype wire

// ==== rv32im_interrupts.sv ====
`default_nettype none

module rv32im_interrupts (
  input  wire                      clk_i,
  input  wire                      reset_i,
  input  wire irq_pkg::irq_vec_t   irq_rise_i,
  input  wire irq_pkg::irq_vec_t   irq_mask_i,
  input  wire irq_pkg::xaddr_t     vector_base_i,
  input  wire                      irq_advance_i,
  input  wire                      irq_clear_i,
  output irq_pkg::irq_vec_t        pending_o,
  output irq_pkg::irq_vec_t        active_o,
  output irq_pkg::irq_state_e      state_o,
  output logic                     irq_request_o,
  output irq_pkg::xaddr_t          trap_pc_o
);

  irq_pkg::irq_state_e state_q;
  irq_pkg::irq_vec_t   pending_q;
  irq_pkg::irq_vec_t   active_q;
  irq_pkg::xaddr_t     trap_pc_q;

  irq_pkg::irq_vec_t   masked_rise;
  irq_pkg::irq_vec_t   lowest;
  irq_pkg::irq_idx_t   active_idx;
  irq_pkg::xaddr_t     trap_offset;
  logic                clear_fire;

  // mask only gates new edges
  assign masked_rise = irq_rise_i & irq_mask_i;
  assign clear_fire  = (state_q == irq_pkg::IRQ_TAKEN) && irq_clear_i;

  // a new edge in the clear cycle keeps the bit set
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= '0;
    end else if (clear_fire) begin
      pending_q <= (pending_q & ~active_q) | masked_rise;
    end else begin
      pending_q <= pending_q | masked_rise;
    end
  end

  // lowest set bit wins
  assign lowest[0] = pending_q[0];
  for (genvar i = 1; i < irq_pkg::INT_VECT_LEN; i++) begin : g_prio
    assign lowest[i] = pending_q[i] && !(|pending_q[i-1:0]);
  end

  // one-hot active line to binary index
  always_comb begin
    active_idx = '0;
    for (int j = 0; j < irq_pkg::INT_VECT_LEN; j++) begin
      if (active_q[j]) begin
        active_idx = irq_pkg::irq_idx_t'(j);
      end
    end
  end

  // one word per vector slot
  assign trap_offset = irq_pkg::xaddr_t'(active_idx) << 2;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= irq_pkg::IRQ_IDLE;
      active_q <= '0;
    end else begin
      case (state_q)
        irq_pkg::IRQ_IDLE: begin
          if (lowest != '0) begin
            active_q <= lowest;
            state_q  <= irq_pkg::IRQ_PENDING;
          end
        end
        irq_pkg::IRQ_PENDING: begin
          if (irq_advance_i) begin
            state_q <= irq_pkg::IRQ_TAKEN;
          end
        end
        irq_pkg::IRQ_TAKEN: begin
          if (irq_clear_i) begin
            active_q <= '0;
            state_q  <= irq_pkg::IRQ_IDLE;
          end
        end
        default: begin
          state_q <= irq_pkg::IRQ_IDLE;
        end
      endcase
    end
  end

  // trap address captured when the core takes the interrupt
  always_ff @(posedge clk_i) begin
    if ((state_q == irq_pkg::IRQ_PENDING) && irq_advance_i) begin
      trap_pc_q <= vector_base_i + trap_offset;
    end
  end

  assign irq_request_o = (state_q == irq_pkg::IRQ_PENDING);
  assign pending_o     = pending_q;
  assign active_o      = active_q;
  assign state_o       = state_q;
  assign trap_pc_o     = trap_pc_q;

endmodule

`default_nettype wire

// ==== irq_subsystem_top.sv ====
`default_nettype none

module irq_subsystem_top (
  input  wire                          clk_i,
  input  wire                          reset_i,
  input  wire irq_pkg::irq_vec_t       irq_lines_i,
  input  wire axil_pkg::axil_req_t     axil_req_i,
  output wire axil_pkg::axil_rsp_t     axil_rsp_o,
  input  wire                          irq_advance_i,
  input  wire                          irq_clear_i,
  output wire                          irq_request_o,
  output wire irq_pkg::xaddr_t         trap_pc_o,
  output wire irq_pkg::irq_state_e     irq_state_o
);

  wire irq_pkg::irq_vec_t   irq_rise;
  wire irq_pkg::irq_vec_t   irq_mask;
  wire irq_pkg::xaddr_t     vector_base;
  wire irq_pkg::irq_vec_t   pending;
  wire irq_pkg::irq_vec_t   active;
  wire irq_pkg::irq_state_e state;

  // external lines into the clock domain
  irq_edge_sync u_edge_sync (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .irq_lines_i (irq_lines_i),
    .irq_rise_o  (irq_rise)
  );

  // software register port
  axil_irq_regs u_regs (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .axil_req_i    (axil_req_i),
    .axil_rsp_o    (axil_rsp_o),
    .pending_i     (pending),
    .active_i      (active),
    .state_i       (state),
    .irq_mask_o    (irq_mask),
    .vector_base_o (vector_base)
  );

  rv32im_interrupts u_ctrl (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .irq_rise_i    (irq_rise),
    .irq_mask_i    (irq_mask),
    .vector_base_i (vector_base),
    .irq_advance_i (irq_advance_i),
    .irq_clear_i   (irq_clear_i),
    .pending_o     (pending),
    .active_o      (active),
    .state_o       (state),
    .irq_request_o (irq_request_o),
    .trap_pc_o     (trap_pc_o)
  );

  assign irq_state_o = state;

endmodule

`default_nettype wire

// ==== tb_irq_subsystem.sv ====
`default_nettype none

module tb_irq_subsystem;

  // five tests of under 500 cycles each, plus margin
  localparam int TIMEOUT_CYCLES = 4000;

  logic                   clk;
  logic                   reset;
  irq_pkg::irq_vec_t      irq_lines;
  axil_pkg::axil_req_t    axil_req;
  logic                   irq_advance;
  logic                   irq_clear;
  wire axil_pkg::axil_rsp_t  axil_rsp;
  wire                       irq_request;
  wire irq_pkg::xaddr_t      trap_pc;
  wire irq_pkg::irq_state_e  irq_state;

  // reference model state
  irq_pkg::irq_vec_t   model_mask;
  irq_pkg::irq_vec_t   model_pending;
  irq_pkg::xaddr_t     model_base;
  irq_pkg::irq_vec_t   lines_now;

  irq_pkg::irq_state_e prev_state;
  irq_pkg::xaddr_t     exp_pc;
  int errors;
  int test_start_errors;
  int tests_bad;
  int cycle_count;

  irq_subsystem_top uut (
    .clk_i         (clk),
    .reset_i       (reset),
    .irq_lines_i   (irq_lines),
    .axil_req_i    (axil_req),
    .axil_rsp_o    (axil_rsp),
    .irq_advance_i (irq_advance),
    .irq_clear_i   (irq_clear),
    .irq_request_o (irq_request),
    .trap_pc_o     (trap_pc),
    .irq_state_o   (irq_state)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic int lowest_line(input irq_pkg::irq_vec_t vec);
    int idx;
    idx = -1;
    for (int i = irq_pkg::INT_VECT_LEN - 1; i >= 0; i--) begin
      if (vec[i]) idx = i;
    end
    return idx;
  endfunction

  // lowest pending line, one word per vector slot
  function automatic irq_pkg::xaddr_t expect_trap(input irq_pkg::irq_vec_t pend,
                                                  input irq_pkg::xaddr_t base);
    return base + irq_pkg::xaddr_t'(lowest_line(pend) * 4);
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("Fail at time %0t: %s expected %h got %h", $time, name, exp_val, act_val);
    errors++;
  endtask

  task automatic end_test(input string name);
    if (errors == test_start_errors) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - test_start_errors);
      tests_bad++;
    end
    test_start_errors = errors;
  endtask

  task automatic axi_write(input axil_pkg::axil_addr_t addr, input axil_pkg::axil_data_t data,
                           input axil_pkg::axil_strb_t strb,
                           input axil_pkg::axil_resp_t exp_resp);
    axil_pkg::axil_resp_t resp;
    @(posedge clk);
    axil_req.aw.addr  <= addr;
    axil_req.aw.valid <= 1'b1;
    axil_req.w.data   <= data;
    axil_req.w.strb   <= strb;
    axil_req.w.valid  <= 1'b1;
    do @(posedge clk); while (!axil_rsp.awready);
    if (axil_rsp.wready !== 1'b1) report_mismatch("wready", 32'd1, 32'(axil_rsp.wready));
    axil_req.aw.valid <= 1'b0;
    axil_req.w.valid  <= 1'b0;
    repeat ($urandom_range(0, 3)) @(posedge clk);
    axil_req.bready <= 1'b1;
    do @(posedge clk); while (!axil_rsp.bvalid);
    resp = axil_rsp.bresp;
    axil_req.bready <= 1'b0;
    if (resp !== exp_resp) report_mismatch("bresp", 32'(exp_resp), 32'(resp));
    // model follows the byte strobes of the writable registers
    for (int b = 0; b < 4; b++) begin
      if (strb[b] && addr == axil_pkg::REG_VBASE) model_base[8*b +: 8] = data[8*b +: 8];
    end
    model_base[1:0] = 2'b00;
    if (strb[0] && addr == axil_pkg::REG_MASK) model_mask = data[7:0];
  endtask

  task automatic axi_read(input axil_pkg::axil_addr_t addr, input axil_pkg::axil_data_t exp_data,
                          input axil_pkg::axil_resp_t exp_resp);
    axil_pkg::axil_data_t data;
    axil_pkg::axil_resp_t resp;
    @(posedge clk);
    axil_req.ar.addr  <= addr;
    axil_req.ar.valid <= 1'b1;
    do @(posedge clk); while (!axil_rsp.arready);
    axil_req.ar.valid <= 1'b0;
    repeat ($urandom_range(0, 3)) @(posedge clk);
    axil_req.rready <= 1'b1;
    do @(posedge clk); while (!axil_rsp.rvalid);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    axil_req.rready <= 1'b0;
    if (resp !== exp_resp) report_mismatch("rresp", 32'(exp_resp), 32'(resp));
    if (data !== exp_data) report_mismatch("rdata", exp_data, data);
  endtask

  task automatic raise_lines(input irq_pkg::irq_vec_t vec);
    irq_pkg::irq_vec_t edges;
    @(posedge clk);
    edges = vec & ~lines_now;
    lines_now = lines_now | vec;
    irq_lines <= lines_now;
    model_pending = model_pending | (edges & model_mask);
    // synchronizer, edge register and pending latch
    repeat (5) @(posedge clk);
  endtask

  task automatic drop_lines(input irq_pkg::irq_vec_t vec);
    @(posedge clk);
    lines_now = lines_now & ~vec;
    irq_lines <= lines_now;
    repeat (4) @(posedge clk);
  endtask

  task automatic take_irq(output int line);
    int served;
    line = lowest_line(model_pending);
    do @(posedge clk); while (!irq_request);
    repeat ($urandom_range(0, 4)) @(posedge clk);
    irq_advance <= 1'b1;
    @(posedge clk);
    irq_advance <= 1'b0;
    do @(posedge clk); while (irq_state != irq_pkg::IRQ_TAKEN);
    served = int'((trap_pc - model_base) >> 2);
    if (served != line) report_mismatch("served line", 32'(line), 32'(served));
  endtask

  task automatic finish_irq(input int line, input irq_pkg::irq_vec_t rearm);
    if (rearm != '0) begin
      // edge pulse lands in the clear cycle
      lines_now = lines_now | rearm;
      irq_lines <= lines_now;
      repeat (3) @(posedge clk);
    end else begin
      repeat ($urandom_range(0, 4)) @(posedge clk);
    end
    irq_clear <= 1'b1;
    @(posedge clk);
    irq_clear <= 1'b0;
    model_pending[line] = 1'b0;
    model_pending = model_pending | (rearm & model_mask);
  endtask

  // trap address check on entry to IRQ_TAKEN
  always @(posedge clk) begin
    if (!reset && irq_state == irq_pkg::IRQ_TAKEN && prev_state != irq_pkg::IRQ_TAKEN) begin
      exp_pc = expect_trap(model_pending, model_base);
      if (trap_pc !== exp_pc) report_mismatch("trap_pc_o", exp_pc, trap_pc);
      if (irq_request !== 1'b0) report_mismatch("irq_request_o", 32'd0, 32'(irq_request));
    end
    prev_state = irq_state;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: test did not finish");
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    int line;
    void'($urandom(32'he41421d7));
    reset = 1'b1;
    irq_lines = '0;
    axil_req = '0;
    irq_advance = 1'b0;
    irq_clear = 1'b0;
    model_mask = '0;
    model_pending = '0;
    model_base = '0;
    lines_now = '0;
    prev_state = irq_pkg::IRQ_IDLE;
    errors = 0;
    test_start_errors = 0;
    tests_bad = 0;
    cycle_count = 0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    axi_read(axil_pkg::REG_MASK, 32'h0, axil_pkg::RESP_OKAY);
    axi_write(axil_pkg::REG_MASK, 32'h1234_56A5, 4'hF, axil_pkg::RESP_OKAY);
    // only the eight line bits exist
    axi_read(axil_pkg::REG_MASK, 32'hA5, axil_pkg::RESP_OKAY);
    axi_write(axil_pkg::REG_VBASE, 32'h8000_1237, 4'hF, axil_pkg::RESP_OKAY);
    axi_read(axil_pkg::REG_VBASE, 32'h8000_1234, axil_pkg::RESP_OKAY);
    axi_write(axil_pkg::REG_VBASE, 32'hFFFF_FFFF, 4'b0010, axil_pkg::RESP_OKAY);
    axi_read(axil_pkg::REG_VBASE, 32'h8000_FF34, axil_pkg::RESP_OKAY);
    axi_write(4'h6, 32'hFFFF_FFFF, 4'hF, axil_pkg::RESP_SLVERR);
    axi_read(axil_pkg::REG_MASK, 32'hA5, axil_pkg::RESP_OKAY);
    axi_read(4'h2, 32'h0, axil_pkg::RESP_SLVERR);
    end_test("register access");

    axi_write(axil_pkg::REG_MASK, 32'hF0, 4'hF, axil_pkg::RESP_OKAY);
    raise_lines(8'h0F);
    axi_read(axil_pkg::REG_PENDING, 32'h0, axil_pkg::RESP_OKAY);
    axi_write(axil_pkg::REG_MASK, 32'hFF, 4'hF, axil_pkg::RESP_OKAY);
    repeat (8) @(posedge clk);
    axi_read(axil_pkg::REG_PENDING, 32'h0, axil_pkg::RESP_OKAY);
    if (irq_state !== irq_pkg::IRQ_IDLE) begin
      report_mismatch("irq_state_o", 32'(irq_pkg::IRQ_IDLE), 32'(irq_state));
    end
    drop_lines(8'h0F);
    end_test("mask gating");

    axi_write(axil_pkg::REG_VBASE, 32'h0040_0100, 4'hF, axil_pkg::RESP_OKAY);
    raise_lines(8'h2C);
    take_irq(line);
    axi_read(axil_pkg::REG_ACTIVE, (32'(irq_pkg::IRQ_TAKEN) << 8) | (32'd1 << line),
             axil_pkg::RESP_OKAY);
    axi_read(axil_pkg::REG_PENDING, 32'(model_pending), axil_pkg::RESP_OKAY);
    finish_irq(line, '0);
    end_test("priority and trap address");

    while (model_pending != '0) begin
      take_irq(line);
      finish_irq(line, '0);
      axi_read(axil_pkg::REG_PENDING, 32'(model_pending), axil_pkg::RESP_OKAY);
    end
    axi_read(axil_pkg::REG_ACTIVE, 32'h0, axil_pkg::RESP_OKAY);
    drop_lines(8'h2C);
    end_test("service order");

    // held line gives one edge only
    raise_lines(8'h40);
    take_irq(line);
    finish_irq(line, '0);
    repeat (40) @(posedge clk);
    if (irq_request !== 1'b0) report_mismatch("irq_request_o", 32'd0, 32'(irq_request));
    axi_read(axil_pkg::REG_PENDING, 32'h0, axil_pkg::RESP_OKAY);
    drop_lines(8'h40);
    // line 1 fires again inside its own handler
    raise_lines(8'h02);
    take_irq(line);
    drop_lines(8'h02);
    finish_irq(line, 8'h02);
    take_irq(line);
    finish_irq(line, '0);
    drop_lines(8'h02);
    raise_lines(8'hD1);
    while (model_pending != '0) begin
      take_irq(line);
      finish_irq(line, '0);
    end
    axi_read(axil_pkg::REG_PENDING, 32'h0, axil_pkg::RESP_OKAY);
    axi_read(axil_pkg::REG_ACTIVE, 32'h0, axil_pkg::RESP_OKAY);
    end_test("edges and back-pressure");

    $display("tests run 5, tests with errors %0d, failed checks %0d", tests_bad, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
irq_pkg.sv
axil_pkg.sv
irq_edge_sync.sv
axil_irq_regs.sv
rv32im_interrupts.sv
irq_subsystem_top.sv
tb_irq_subsystem.sv

// ==== run_verilator.sh ====
#!/usr/bin/env bash
# build and run the interrupt subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_irq_subsystem -f vlog.f; then
  echo "verilator build failed"
  exit 1
fi

if ! sim_out=$(./obj_dir/Vtb_irq_subsystem); then
  echo "$sim_out"
  echo "simulation exited with an error"
  exit 1
fi
echo "$sim_out"

if echo "$sim_out" | grep -q "^STATUS: PASS$"; then
  exit 0
fi
exit 1
